// ==== sources.f ====
rtl/xt_video_pkg.sv
rtl/cpu_clock_enables.sv
rtl/splash_hold.sv
rtl/luma_weigh.sv
rtl/monitor_tint.sv
rtl/xt_display_core.sv
+incdir+verif
verif/tb_xt_display_core.sv

// ==== verif/tb_checks.svh ====
// Reference model and result checks
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Error tallies by kind
int mismatch_count = 0;
int fault_count    = 0;

////////////////////////////////////////
// Reference model
////////////////////////////////////////

// One channel weight rounded to nearest 1/1024
function automatic int weighted(input color_t code, input int factor);
	return (int'(code) * factor + 512) / 1024;
endfunction

function automatic color_t ref_luma(input color_t r, input color_t g, input color_t b);
	int sum;
	sum = weighted(r, RED_FACTOR) + weighted(g, GREEN_FACTOR) + weighted(b, BLUE_FACTOR);
	return color_t'(sum);
endfunction

// Channel 0 is red, 1 green, 2 blue
function automatic vga_t ref_channel(input tint_mode_t mode, input int channel,
		input color_t raw, input color_t luma);
	int level;
	case (mode)
		TINT_COLOR: level = raw;
		TINT_GREEN: level = (channel == 1) ? luma : 0;
		TINT_AMBER: level = (channel == 0) ? luma : ((channel == 1) ? luma / 2 : 0);
		default:    level = luma;
	endcase
	// Level sits above two zero bits
	return vga_t'(level * 4);
endfunction

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

task automatic compare_vga(input string what, input vga_t got, input vga_t expected);
	if (got !== expected) begin
		mismatch_count++;
		$display("MISMATCH at %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, expected);
	end
endtask

task automatic compare_flag(input string what, input logic got, input logic expected);
	if (got !== expected) begin
		mismatch_count++;
		$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, expected);
	end
endtask

// Strobe spacing in cycles
task automatic compare_interval(input string what, input int got, input int expected);
	if (got != expected) begin
		mismatch_count++;
		$display("MISMATCH at %0t: %s is %0d cycles, expected %0d", $time, what, got, expected);
	end
endtask

task automatic compare_mode_pixel(input int row, input tint_mode_t mode,
		input vga_t got_r, input vga_t got_g, input vga_t got_b,
		input vga_t exp_r, input vga_t exp_g, input vga_t exp_b);
	string tag;
	tag = $sformatf("row %0d mode %0d", row, mode);
	compare_vga({tag, " vga_r"}, got_r, exp_r);
	compare_vga({tag, " vga_g"}, got_g, exp_g);
	compare_vga({tag, " vga_b"}, got_b, exp_b);
endtask

task automatic report_fault(input string what);
	fault_count++;
	$display("ERROR at %0t: %s", $time, what);
endtask

`endif

// ==== verif/tb_xt_display_core.sv ====
// XT display core testbench
`timescale 1ns/100ps

module tb_xt_display_core import xt_video_pkg::*; ();

	localparam int TABLE_LEN        = 64;
	localparam int FIXED_ROWS       = 8;
	localparam int SIM_SECOND_TICKS = 20;
	localparam int RESET_CYCLES     = 8;
	localparam int SPLASH_CYCLES    = SPLASH_SECONDS * SIM_SECOND_TICKS;
	localparam int STROBE_CYCLES    = 30;
	localparam int WATCHDOG_CYCLES  = TABLE_LEN + 2 * SPLASH_SECONDS * SIM_SECOND_TICKS + 500;

	typedef struct packed {
		tint_mode_t mode;
		color_t     r;
		color_t     g;
		color_t     b;
		logic       de;
		logic       hs;
		logic       vs;
		vga_t       exp_r;
		vga_t       exp_g;
		vga_t       exp_b;
	} pixel_row_t;

	logic       clk_14_318 = 1'b0;
	logic       reset, turbo, skip_splash;
	tint_mode_t tint_mode;
	color_t     red, green, blue;
	logic       de, hsync, vsync;
	logic       cpu_ce, periph_ce, splash_active, cpu_reset;
	vga_t       vga_r, vga_g, vga_b;
	logic       vga_de, vga_hs, vga_vs;

	pixel_row_t  pixel_table [TABLE_LEN];
	logic [31:0] rng_state = 32'd28563;

	`include "tb_checks.svh"

	// 4 ns period
	always #2 clk_14_318 = ~clk_14_318;

	xt_display_core #(.second_ticks(TICK_W'(SIM_SECOND_TICKS))) uut (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state ^ (state << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////

	task automatic build_table();
		pixel_row_t row;
		color_t     luma;
		for (int k = 0; k < TABLE_LEN; k++) begin
			if (k < FIXED_ROWS) begin
				// All-dark and all-bright in each mode
				row.mode = tint_mode_t'(k / 2);
				row.r = (k % 2 == 1) ? color_t'(63) : color_t'(0);
				row.g = row.r;
				row.b = row.r;
				row.de = 1'b1;
				row.hs = (k % 2 == 1);
				row.vs = (k >= 4);
			end else begin
				rng_state = xorshift32(rng_state);
				{row.vs, row.hs, row.de, row.b, row.g, row.r} = rng_state[20:0];
				row.mode = tint_mode_t'(rng_state[22:21]);
			end
			luma = ref_luma(row.r, row.g, row.b);
			row.exp_r = ref_channel(row.mode, 0, row.r, luma);
			row.exp_g = ref_channel(row.mode, 1, row.g, luma);
			row.exp_b = ref_channel(row.mode, 2, row.b, luma);
			pixel_table[k] = row;
		end
	endtask

	task automatic drive_row(input int k);
		tint_mode = pixel_table[k].mode;
		{red, green, blue} = {pixel_table[k].r, pixel_table[k].g, pixel_table[k].b};
		{de, hsync, vsync} = {pixel_table[k].de, pixel_table[k].hs, pixel_table[k].vs};
	endtask

	task automatic check_row(input int k);
		compare_mode_pixel(k, pixel_table[k].mode, vga_r, vga_g, vga_b,
			pixel_table[k].exp_r, pixel_table[k].exp_g, pixel_table[k].exp_b);
		compare_flag($sformatf("row %0d vga_de", k), vga_de, pixel_table[k].de);
		compare_flag($sformatf("row %0d vga_hs", k), vga_hs, pixel_table[k].hs);
		compare_flag($sformatf("row %0d vga_vs", k), vga_vs, pixel_table[k].vs);
	endtask

	////////////////////////////////////////
	// Test phases
	////////////////////////////////////////

	task automatic apply_reset();
		reset = 1'b1;
		// Bright pixel and live sync while reset holds the video path at 0
		tint_mode = TINT_MONO;
		{red, green, blue} = {3{color_t'(63)}};
		{de, hsync, vsync} = 3'b111;
		repeat (RESET_CYCLES) begin
			@(negedge clk_14_318);
			compare_flag("cpu_ce in reset", cpu_ce, 1'b0);
			compare_flag("periph_ce in reset", periph_ce, 1'b0);
			compare_flag("splash_active in reset", splash_active, 1'b1);
			compare_flag("cpu_reset in reset", cpu_reset, 1'b1);
			compare_vga("video in reset", vga_r | vga_g | vga_b, 8'h00);
			compare_flag("sync in reset", vga_de | vga_hs | vga_vs, 1'b0);
		end
		reset = 1'b0;
	endtask

	// Hold lasts exactly the splash time, then stays low
	task automatic check_splash_timeout();
		for (int c = 1; c <= SPLASH_CYCLES + 20; c++) begin
			@(negedge clk_14_318);
			compare_flag($sformatf("splash_active at %0d", c), splash_active, c < SPLASH_CYCLES);
			compare_flag($sformatf("cpu_reset at %0d", c), cpu_reset, c < SPLASH_CYCLES);
		end
	endtask

	task automatic check_skip();
		repeat (10) begin
			@(negedge clk_14_318);
			compare_flag("splash_active before skip", splash_active, 1'b1);
		end
		skip_splash = 1'b1;
		@(negedge clk_14_318);
		skip_splash = 1'b0;
		repeat (10) begin
			compare_flag("splash_active after skip", splash_active, 1'b0);
			compare_flag("cpu_reset after skip", cpu_reset, 1'b0);
			@(negedge clk_14_318);
		end
	endtask

	task automatic check_strobes(input logic fast);
		int cpu_period;
		int cpu_last, cpu_seen, periph_last, periph_seen;
		cpu_period = fast ? FAST_DIV : SLOW_DIV;
		{cpu_last, cpu_seen, periph_last, periph_seen} = '0;
		turbo = fast;
		for (int c = 1; c <= STROBE_CYCLES; c++) begin
			@(negedge clk_14_318);
			// First interval after the switch may straddle it
			if (cpu_ce === 1'b1) begin
				if (cpu_seen >= 2)
					compare_interval("cpu_ce interval", c - cpu_last, cpu_period);
				cpu_last = c;
				cpu_seen++;
			end
			if (periph_ce === 1'b1) begin
				if (periph_seen >= 2)
					compare_interval("periph_ce interval", c - periph_last, SLOW_DIV);
				periph_last = c;
				periph_seen++;
			end
		end
		if (cpu_seen < STROBE_CYCLES / cpu_period - 1)
			report_fault($sformatf("cpu_ce strobe missing, only %0d pulses", cpu_seen));
		if (periph_seen < STROBE_CYCLES / SLOW_DIV - 1)
			report_fault($sformatf("periph_ce strobe missing, only %0d pulses", periph_seen));
	endtask

	////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////

	initial begin
		{reset, turbo, skip_splash} = 3'b100;
		tint_mode = TINT_COLOR;
		{red, green, blue, de, hsync, vsync} = '0;
		build_table();
		apply_reset();
		check_splash_timeout();
		apply_reset();
		check_skip();
		check_strobes(1'b0);
		check_strobes(1'b1);
		// Outputs lag the inputs by the pipeline depth
		for (int i = 0; i < TABLE_LEN + VIDEO_LATENCY; i++) begin
			@(negedge clk_14_318);
			if (i >= VIDEO_LATENCY)
				check_row(i - VIDEO_LATENCY);
			if (i < TABLE_LEN)
				drive_row(i);
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
		if (mismatch_count == 0 && fault_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_14_318);
		$display("Timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

endmodule

// ==== rtl/xt_display_core.sv ====
// XT display and timing core
//
`timescale 1ns/100ps

module xt_display_core import xt_video_pkg::*; #(
	parameter logic [TICK_W-1:0] second_ticks = SECOND_TICKS_DEFAULT
) (
	input  logic       clk_14_318,
	input  logic       reset,
	input  logic       turbo,
	input  logic       skip_splash,
	input  tint_mode_t tint_mode,
	input  color_t     red,
	input  color_t     green,
	input  color_t     blue,
	input  logic       de,
	input  logic       hsync,
	input  logic       vsync,
	output logic       cpu_ce,
	output logic       periph_ce,
	output logic       splash_active,
	output logic       cpu_reset,
	output vga_t       vga_r,
	output vga_t       vga_g,
	output vga_t       vga_b,
	output logic       vga_de,
	output logic       vga_hs,
	output logic       vga_vs
);

	// Stage 1 to stage 2
	color_t     luma;
	tint_mode_t mode_d;
	color_t     red_d;
	color_t     green_d;
	color_t     blue_d;
	logic       de_d;
	logic       hsync_d;
	logic       vsync_d;

	////////////////////////////////////////
	// Timing
	////////////////////////////////////////

	cpu_clock_enables u_clock_enables (
		.clk_14_318 (clk_14_318),
		.reset      (reset),
		.turbo      (turbo),
		.cpu_ce     (cpu_ce),
		.periph_ce  (periph_ce)
	);

	// Machine held in reset while the logo shows
	splash_hold #(
		.second_ticks (second_ticks)
	) u_splash_hold (
		.clk_14_318    (clk_14_318),
		.reset         (reset),
		.skip_splash   (skip_splash),
		.splash_active (splash_active),
		.cpu_reset     (cpu_reset)
	);

	////////////////////////////////////////
	// Video path
	////////////////////////////////////////

	luma_weigh u_luma_weigh (
		.clk_14_318 (clk_14_318),
		.reset      (reset),
		.tint_mode  (tint_mode),
		.red        (red),
		.green      (green),
		.blue       (blue),
		.de         (de),
		.hsync      (hsync),
		.vsync      (vsync),
		.luma       (luma),
		.mode_d     (mode_d),
		.red_d      (red_d),
		.green_d    (green_d),
		.blue_d     (blue_d),
		.de_d       (de_d),
		.hsync_d    (hsync_d),
		.vsync_d    (vsync_d)
	);

	// Combines luma and raw colour per the pixel's mode
	monitor_tint u_monitor_tint (
		.clk_14_318 (clk_14_318),
		.reset      (reset),
		.mode_d     (mode_d),
		.luma       (luma),
		.red_d      (red_d),
		.green_d    (green_d),
		.blue_d     (blue_d),
		.de_d       (de_d),
		.hsync_d    (hsync_d),
		.vsync_d    (vsync_d),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b),
		.vga_de     (vga_de),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs)
	);

endmodule

// ==== rtl/monitor_tint.sv ====
// Monitor tint video stage
//
`timescale 1ns/100ps

module monitor_tint import xt_video_pkg::*; (
	input  logic       clk_14_318,
	input  logic       reset,
	input  tint_mode_t mode_d,
	input  color_t     luma,
	input  color_t     red_d,
	input  color_t     green_d,
	input  color_t     blue_d,
	input  logic       de_d,
	input  logic       hsync_d,
	input  logic       vsync_d,
	output vga_t       vga_r,
	output vga_t       vga_g,
	output vga_t       vga_b,
	output logic       vga_de,
	output logic       vga_hs,
	output logic       vga_vs
);

	// Tinted 6-bit channels
	color_t tint_r;
	color_t tint_g;
	color_t tint_b;

	////////////////////////////////////////
	// Tint select
	////////////////////////////////////////

	always_comb begin
		tint_r = '0;
		tint_g = '0;
		tint_b = '0;
		case (mode_d)
			TINT_COLOR: begin
				tint_r = red_d;
				tint_g = green_d;
				tint_b = blue_d;
			end
			// Green phosphor
			TINT_GREEN: begin
				tint_g = luma;
			end
			// Amber with green at half strength
			TINT_AMBER: begin
				tint_r = luma;
				tint_g = luma >> 1;
			end
			// White phosphor
			TINT_MONO: begin
				tint_r = luma;
				tint_g = luma;
				tint_b = luma;
			end
		endcase
	end

	////////////////////////////////////////
	// Stage 2 register
	////////////////////////////////////////

	always_ff @(posedge clk_14_318) begin
		if (reset) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_de <= 1'b0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			// Top-aligned in the 8-bit channel
			vga_r  <= {tint_r, {(VGA_W - COLOR_W){1'b0}}};
			vga_g  <= {tint_g, {(VGA_W - COLOR_W){1'b0}}};
			vga_b  <= {tint_b, {(VGA_W - COLOR_W){1'b0}}};
			vga_de <= de_d;
			vga_hs <= hsync_d;
			vga_vs <= vsync_d;
		end
	end

endmodule

// ==== rtl/luma_weigh.sv ====
// Luma weighting video stage
//
`timescale 1ns/100ps

module luma_weigh import xt_video_pkg::*; (
	input  logic       clk_14_318,
	input  logic       reset,
	input  tint_mode_t tint_mode,
	input  color_t     red,
	input  color_t     green,
	input  color_t     blue,
	input  logic       de,
	input  logic       hsync,
	input  logic       vsync,
	output color_t     luma,
	output tint_mode_t mode_d,
	output color_t     red_d,
	output color_t     green_d,
	output color_t     blue_d,
	output logic       de_d,
	output logic       hsync_d,
	output logic       vsync_d
);

	// Per-channel weight lookups
	color_t red_table   [LUMA_ENTRIES];
	color_t green_table [LUMA_ENTRIES];
	color_t blue_table  [LUMA_ENTRIES];

	color_t red_w;
	color_t green_w;
	color_t blue_w;

	// Rounded index * factor / 1024
	function automatic color_t weight(input int index, input int factor);
		return color_t'((index * factor + LUMA_ROUND) >> LUMA_SHIFT);
	endfunction

	////////////////////////////////////////
	// Weight tables
	////////////////////////////////////////

	// Constant weights for every channel code
	for (genvar i = 0; i < LUMA_ENTRIES; i++) begin : g_table
		assign red_table[i]   = weight(i, RED_FACTOR);
		assign green_table[i] = weight(i, GREEN_FACTOR);
		assign blue_table[i]  = weight(i, BLUE_FACTOR);
	end

	assign red_w   = red_table[red];
	assign green_w = green_table[green];
	assign blue_w  = blue_table[blue];

	////////////////////////////////////////
	// Stage 1 register
	////////////////////////////////////////

	always_ff @(posedge clk_14_318) begin
		if (reset) begin
			luma    <= '0;
			mode_d  <= TINT_COLOR;
			red_d   <= '0;
			green_d <= '0;
			blue_d  <= '0;
			de_d    <= 1'b0;
			hsync_d <= 1'b0;
			vsync_d <= 1'b0;
		end else begin
			// Factors add to 1024 so the sum stays in 6 bits
			luma    <= red_w + green_w + blue_w;
			// Mode rides along with its pixel
			mode_d  <= tint_mode;
			red_d   <= red;
			green_d <= green;
			blue_d  <= blue;
			de_d    <= de;
			hsync_d <= hsync;
			vsync_d <= vsync;
		end
	end

endmodule

// ==== rtl/splash_hold.sv ====
// Power-on splash hold
//
`timescale 1ns/100ps

module splash_hold import xt_video_pkg::*; #(
	parameter logic [TICK_W-1:0] second_ticks = SECOND_TICKS_DEFAULT
) (
	input  logic clk_14_318,
	input  logic reset,
	input  logic skip_splash,
	output logic splash_active,
	output logic cpu_reset
);

	// Cycles within the current second
	logic [TICK_W-1:0] tick_cnt;
	// Whole seconds since reset
	logic [SEC_W-1:0]  sec_cnt;

	logic tick_wrap;
	logic last_tick;
	logic hold_done;
	logic splash_next;

	assign tick_wrap = (tick_cnt == second_ticks - 1'b1);

	// Final cycle of the final second
	assign last_tick = tick_wrap && (sec_cnt == SEC_W'(SPLASH_SECONDS - 1));

	// User skip wins over the timer
	assign hold_done = skip_splash || last_tick;

	// Hold can only fall, never rise again
	assign splash_next = splash_active && !hold_done;

	////////////////////////////////////////
	// Second timer
	////////////////////////////////////////

	always_ff @(posedge clk_14_318) begin
		if (reset) begin
			tick_cnt <= '0;
			sec_cnt  <= '0;
		end else if (splash_active) begin
			// Counters freeze once the hold clears
			if (tick_wrap) begin
				tick_cnt <= '0;
				sec_cnt  <= sec_cnt + 1'b1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Hold flag and CPU reset
	////////////////////////////////////////

	always_ff @(posedge clk_14_318) begin
		if (reset) begin
			splash_active <= 1'b1;
			cpu_reset     <= 1'b1;
		end else begin
			splash_active <= splash_next;
			// CPU and chipset leave reset together with the splash
			cpu_reset     <= splash_next;
		end
	end

endmodule

// ==== rtl/cpu_clock_enables.sv ====
// CPU and peripheral clock enables
//
`timescale 1ns/100ps

module cpu_clock_enables import xt_video_pkg::*; (
	input  logic clk_14_318,
	input  logic reset,
	input  logic turbo,
	output logic cpu_ce,
	output logic periph_ce
);

	// Peripheral side always runs at 4.77 MHz
	logic [CE_CNT_W-1:0] periph_cnt;
	logic                periph_wrap;

	// CPU side with its ratio picked at each wrap
	logic [CE_CNT_W-1:0] cpu_cnt;
	logic [CE_CNT_W-1:0] cpu_last;
	logic                cpu_fast;
	logic                cpu_wrap;

	assign periph_wrap = (periph_cnt == CE_CNT_W'(SLOW_DIV - 1));

	// Terminal count for the current CPU period
	assign cpu_last = cpu_fast ? CE_CNT_W'(FAST_DIV - 1) : CE_CNT_W'(SLOW_DIV - 1);
	assign cpu_wrap = (cpu_cnt == cpu_last);

	////////////////////////////////////////
	// Peripheral divider
	////////////////////////////////////////

	always_ff @(posedge clk_14_318) begin
		if (reset) begin
			periph_cnt <= '0;
			periph_ce  <= 1'b0;
		end else begin
			periph_ce <= periph_wrap;
			if (periph_wrap)
				periph_cnt <= '0;
			else
				periph_cnt <= periph_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// CPU divider
	////////////////////////////////////////

	always_ff @(posedge clk_14_318) begin
		if (reset) begin
			cpu_cnt  <= '0;
			cpu_ce   <= 1'b0;
			// First period already follows the switch
			cpu_fast <= turbo;
		end else begin
			cpu_ce <= cpu_wrap;
			if (cpu_wrap) begin
				cpu_cnt  <= '0;
				// Speed change only on a period boundary
				cpu_fast <= turbo;
			end else begin
				cpu_cnt <= cpu_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/xt_video_pkg.sv ====
// XT display core shared definitions
//

package xt_video_pkg;

	////////////////////////////////////////
	// Video widths
	////////////////////////////////////////

	// Incoming CGA-style channel
	localparam int COLOR_W = 6;
	// Outgoing VGA channel
	localparam int VGA_W   = 8;

	typedef logic [COLOR_W-1:0] color_t;
	typedef logic [VGA_W-1:0]   vga_t;

	// Monitor type chosen by the user
	typedef enum logic [1:0] {
		TINT_COLOR = 2'd0,
		TINT_GREEN = 2'd1,
		TINT_AMBER = 2'd2,
		TINT_MONO  = 2'd3
	} tint_mode_t;

	// Luma factors in 1/1024 units
	localparam int RED_FACTOR   = 218;
	localparam int GREEN_FACTOR = 732;
	localparam int BLUE_FACTOR  = 74;
	// Round to nearest before the shift
	localparam int LUMA_SHIFT   = 10;
	localparam int LUMA_ROUND   = 512;
	// One table entry per channel code
	localparam int LUMA_ENTRIES = 1 << COLOR_W;

	// Pixel in to pixel out
	localparam int VIDEO_LATENCY = 2;

	////////////////////////////////////////
	// Splash hold
	////////////////////////////////////////

	localparam int SPLASH_SECONDS = 5;
	localparam int TICK_W         = 24;
	localparam int SEC_W          = $clog2(SPLASH_SECONDS + 1);
	// One second at 14.318 MHz
	localparam logic [TICK_W-1:0] SECOND_TICKS_DEFAULT = 24'd14318000;

	////////////////////////////////////////
	// Clock enables
	////////////////////////////////////////

	// 14.318 / 3 = 4.77 MHz
	localparam int SLOW_DIV = 3;
	// 14.318 / 2 = 7.16 MHz
	localparam int FAST_DIV = 2;
	// Wide enough for the slower ratio
	localparam int CE_CNT_W = $clog2(SLOW_DIV);

endpackage
